/* build.f */
+incdir+hdl
hdl/l2_axi_pkg.sv
hdl/l2_order_if.sv
hdl/l2_axi_rd_channel.sv
hdl/l2_axi_wr_channel.sv
hdl/l2_rw_order_guard.sv
hdl/l2_axi_bridge.sv
test/tb_l2_axi_bridge.sv

/* hdl/l2_axi_bridge.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// subordinate must accept INCR bursts with ID 0
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none
`include "l2_axi_params.svh"

module l2_axi_bridge import l2_axi_pkg::*; (
    input  logic                    clk,
    input  logic                    rstn,
    // L2 read
    input  logic                    l2_rvalid,
    output logic                    l2_raddrOK,
    output logic                    l2_rready,
    input  logic [`L2_ADDR_W-1:0]   l2_raddr,
    output logic [`L2_DATA_W-1:0]   l2_rdata,
    output logic                    l2_rlast,
    output logic                    l2_rerr,
    input  logic [7:0]              l2_rlen,
    input  logic [2:0]              l2_rsize,
    // L2 write
    input  logic                    l2_wvalid,
    input  logic                    l2_wwvalid,
    output logic                    l2_waddrOK,
    output logic                    l2_wready,
    input  logic [`L2_ADDR_W-1:0]   l2_waddr,
    input  logic [`L2_DATA_W-1:0]   l2_wdata,
    input  logic [`L2_DATA_W/8-1:0] l2_wstrb,
    input  logic                    l2_wlast,
    input  logic [7:0]              l2_wlen,
    input  logic [2:0]              l2_wsize,
    output logic                    l2_bvalid,
    output logic                    l2_berr,
    input  logic                    l2_bready,
    // AXI read
    output logic [`L2_ADDR_W-1:0]   araddr,
    output logic                    arvalid,
    input  logic                    arready,
    output logic [7:0]              arlen,
    output logic [2:0]              arsize,
    output logic [1:0]              arburst,
    input  logic [`L2_DATA_W-1:0]   rdata,
    input  axi_resp_t               rresp,
    input  logic                    rvalid,
    output logic                    rready,
    input  logic                    rlast,
    // AXI write
    output logic [`L2_ADDR_W-1:0]   awaddr,
    output logic                    awvalid,
    input  logic                    awready,
    output logic [7:0]              awlen,
    output logic [2:0]              awsize,
    output logic [1:0]              awburst,
    output logic [`L2_DATA_W-1:0]   wdata,
    output logic [`L2_DATA_W/8-1:0] wstrb,
    output logic                    wvalid,
    input  logic                    wready,
    output logic                    wlast,
    input  axi_resp_t               bresp,
    input  logic                    bvalid,
    output logic                    bready
);
    l2_order_if ord_if (.clk(clk), .rstn(rstn));

    assign arburst = AXI_BURST_INCR;
    assign awburst = AXI_BURST_INCR;

    l2_axi_rd_channel rd_channel_i (
        .clk, .rstn,
        .l2_rvalid, .l2_raddrOK, .l2_rready, .l2_raddr, .l2_rdata,
        .l2_rlast, .l2_rerr, .l2_rlen, .l2_rsize,
        .araddr, .arvalid, .arready, .arlen, .arsize,
        .rdata, .rresp, .rvalid, .rready, .rlast,
        .ord        (ord_if)
    );

    l2_axi_wr_channel wr_channel_i (
        .clk, .rstn,
        .l2_wvalid, .l2_wwvalid, .l2_waddrOK, .l2_wready, .l2_waddr,
        .l2_wdata, .l2_wstrb, .l2_wlast, .l2_wlen, .l2_wsize,
        .l2_bvalid, .l2_berr, .l2_bready,
        .awaddr, .awvalid, .awready, .awlen, .awsize,
        .wdata, .wstrb, .wvalid, .wready, .wlast,
        .bresp, .bvalid, .bready,
        .ord        (ord_if)
    );

    l2_rw_order_guard order_guard_i (
        .ord (ord_if) // read-after-write hold
    );

endmodule

`default_nettype wire

/* hdl/l2_axi_params.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// widths fixed at 32-bit address and data, 16-byte cache lines
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef L2_AXI_PARAMS_SVH
`define L2_AXI_PARAMS_SVH

`define L2_ADDR_W       32
`define L2_DATA_W       32

// low address bits inside one line
`define L2_LINE_OFS_W   4

`define L2_FILL_WORD    32'hABCD1234 // returned for errored read beats

`endif

/* hdl/l2_axi_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// only INCR bursts are issued by the bridge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package l2_axi_pkg;

    // xRESP encoding, bit 1 marks an error
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_t;

    localparam logic [1:0] AXI_BURST_INCR = 2'b01;

endpackage

`default_nettype wire

/* hdl/l2_axi_rd_channel.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one burst at a time, no back-pressure from the L2 on R
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none
`include "l2_axi_params.svh"

module l2_axi_rd_channel import l2_axi_pkg::*; (
    input  logic                  clk,
    input  logic                  rstn,
    // L2 side
    input  logic                  l2_rvalid,
    output logic                  l2_raddrOK,
    output logic                  l2_rready,
    input  logic [`L2_ADDR_W-1:0] l2_raddr,
    output logic [`L2_DATA_W-1:0] l2_rdata,
    output logic                  l2_rlast,
    output logic                  l2_rerr,
    input  logic [7:0]            l2_rlen,
    input  logic [2:0]            l2_rsize,
    // AR
    output logic [`L2_ADDR_W-1:0] araddr,
    output logic                  arvalid,
    input  logic                  arready,
    output logic [7:0]            arlen,
    output logic [2:0]            arsize,
    // R
    input  logic [`L2_DATA_W-1:0] rdata,
    input  axi_resp_t             rresp,
    input  logic                  rvalid,
    output logic                  rready,
    input  logic                  rlast,
    l2_order_if.rd                ord
);
    localparam logic [1:0] RD_IDLE = 2'd0;
    localparam logic [1:0] RD_ADDR = 2'd1;
    localparam logic [1:0] RD_DATA = 2'd2;

    logic [1:0]            state;
    logic                  start;
    logic                  beat_err;
    logic [`L2_ADDR_W-1:0] addr_q;
    logic [7:0]            len_q;
    logic [2:0]            size_q;

    assign ord.rd_req  = (state == RD_IDLE) && l2_rvalid;
    assign ord.rd_addr = l2_raddr;
    assign start       = ord.rd_req && !ord.rd_hold;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= RD_IDLE;
        end else begin
            case (state)
                RD_IDLE: if (start) state <= RD_ADDR;
                RD_ADDR: if (arready) state <= RD_DATA;
                RD_DATA: if (rvalid && rlast) state <= RD_IDLE;
                default: state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            addr_q <= l2_raddr;
            len_q  <= l2_rlen;
            size_q <= l2_rsize;
        end
    end

    assign araddr  = addr_q;
    assign arlen   = len_q;
    assign arsize  = size_q;
    assign arvalid = (state == RD_ADDR);
    assign rready  = (state == RD_DATA);

    assign beat_err   = (rresp == SLVERR) || (rresp == DECERR);
    assign l2_raddrOK = (state == RD_DATA);
    assign l2_rready  = (state == RD_DATA) && rvalid; // one pulse per beat
    assign l2_rlast   = (state == RD_DATA) && rvalid && rlast;
    assign l2_rerr    = (state == RD_DATA) && rvalid && beat_err;
    assign l2_rdata   = beat_err ? `L2_FILL_WORD : rdata;

    // R beats only for an accepted burst
    r_in_data_a: assert property (@(posedge clk) disable iff (!rstn)
        rvalid |-> (state == RD_DATA));

    // held request must keep its address
    held_addr_stable_a: assert property (@(posedge clk) disable iff (!rstn)
        (state == RD_IDLE) && ord.rd_hold |=> $stable(l2_raddr));

endmodule

`default_nettype wire

/* hdl/l2_axi_wr_channel.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// W beats pass straight through, L2 paces them with l2_wwvalid
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none
`include "l2_axi_params.svh"

module l2_axi_wr_channel import l2_axi_pkg::*; (
    input  logic                    clk,
    input  logic                    rstn,
    // L2 side
    input  logic                    l2_wvalid,
    input  logic                    l2_wwvalid,
    output logic                    l2_waddrOK,
    output logic                    l2_wready,
    input  logic [`L2_ADDR_W-1:0]   l2_waddr,
    input  logic [`L2_DATA_W-1:0]   l2_wdata,
    input  logic [`L2_DATA_W/8-1:0] l2_wstrb,
    input  logic                    l2_wlast,
    input  logic [7:0]              l2_wlen,
    input  logic [2:0]              l2_wsize,
    output logic                    l2_bvalid,
    output logic                    l2_berr,
    input  logic                    l2_bready,
    // AW
    output logic [`L2_ADDR_W-1:0]   awaddr,
    output logic                    awvalid,
    input  logic                    awready,
    output logic [7:0]              awlen,
    output logic [2:0]              awsize,
    // W
    output logic [`L2_DATA_W-1:0]   wdata,
    output logic [`L2_DATA_W/8-1:0] wstrb,
    output logic                    wvalid,
    input  logic                    wready,
    output logic                    wlast,
    // B
    input  axi_resp_t               bresp,
    input  logic                    bvalid,
    output logic                    bready,
    l2_order_if.wr                  ord
);
    localparam logic [1:0] WR_IDLE = 2'd0;
    localparam logic [1:0] WR_ADDR = 2'd1;
    localparam logic [1:0] WR_DATA = 2'd2;
    localparam logic [1:0] WR_RESP = 2'd3;

    logic [1:0]            state;
    logic                  start;
    logic                  in_data;
    logic                  in_resp;
    logic [`L2_ADDR_W-1:0] addr_q;  // held until B so the guard sees it
    logic [7:0]            len_q;
    logic [2:0]            size_q;

    assign start   = (state == WR_IDLE) && l2_wvalid;
    assign in_data = (state == WR_DATA);
    assign in_resp = (state == WR_RESP);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= WR_IDLE;
        end else begin
            case (state)
                WR_IDLE: if (start) state <= WR_ADDR;
                WR_ADDR: if (awready) state <= WR_DATA;
                WR_DATA: if (wvalid && wready && wlast) state <= WR_RESP;
                WR_RESP: if (bvalid && l2_bready) state <= WR_IDLE;
                default: state <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            addr_q <= l2_waddr;
            len_q  <= l2_wlen;
            size_q <= l2_wsize;
        end
    end

    assign ord.wr_busy = (state != WR_IDLE);
    assign ord.wr_addr = addr_q;

    assign awaddr  = addr_q;
    assign awlen   = len_q;
    assign awsize  = size_q;
    assign awvalid = (state == WR_ADDR);

    assign wdata      = l2_wdata;
    assign wstrb      = l2_wstrb;
    assign wvalid     = in_data && l2_wwvalid;
    assign wlast      = in_data && l2_wlast; // L2 must pair it with l2_wwvalid
    assign l2_wready  = in_data && wready;
    assign l2_waddrOK = in_data;

    assign bready    = in_resp && l2_bready;
    assign l2_bvalid = in_resp && bvalid;
    assign l2_berr   = in_resp && bvalid && ((bresp == SLVERR) || (bresp == DECERR));

    wlast_with_wvalid_a: assert property (@(posedge clk) disable iff (!rstn)
        wlast |-> wvalid);

    // B only after the last W beat
    b_in_resp_a: assert property (@(posedge clk) disable iff (!rstn)
        bvalid |-> in_resp);

endmodule

`default_nettype wire

/* hdl/l2_order_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// clk and rstn are carried for the guard's checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none
`include "l2_axi_params.svh"

interface l2_order_if (input logic clk, input logic rstn);
    logic                  rd_req;  // read pending in idle
    logic [`L2_ADDR_W-1:0] rd_addr;
    logic                  rd_hold;
    logic                  wr_busy; // write channel not idle
    logic [`L2_ADDR_W-1:0] wr_addr;

    modport rd    (output rd_req, rd_addr, input rd_hold);
    modport wr    (output wr_busy, wr_addr);
    modport guard (input clk, rstn, rd_req, rd_addr, wr_busy, wr_addr, output rd_hold);
endinterface

`default_nettype wire

/* hdl/l2_rw_order_guard.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// same-line match only, offset bits ignored
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none
`include "l2_axi_params.svh"

module l2_rw_order_guard (
    l2_order_if.guard ord
);
    localparam int LINE_W = `L2_ADDR_W - `L2_LINE_OFS_W;

    logic [LINE_W-1:0] rd_line;
    logic [LINE_W-1:0] wr_line;
    logic              same_line;

    assign rd_line   = ord.rd_addr[`L2_ADDR_W-1:`L2_LINE_OFS_W];
    assign wr_line   = ord.wr_addr[`L2_ADDR_W-1:`L2_LINE_OFS_W];
    assign same_line = (rd_line == wr_line);

    // read waits for the older write to finish its B
    assign ord.rd_hold = ord.rd_req && ord.wr_busy && same_line;

    // a held read stays pending until released
    hold_keeps_req_a: assert property (@(posedge ord.clk) disable iff (!ord.rstn)
        ord.rd_hold |=> ord.rd_req);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Compile and run the bridge testbench with Verilator, from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_l2_axi_bridge -f build.f -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "compile failed, see build.log"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

if grep -q "TESTS FAILED" sim.log; then
    echo "simulation reported failures, see sim.log"
    exit 1
fi

echo "simulation finished without failures"
exit 0

/* test/l2_axi_patterns.txt */
# kind: W write, R read, H write+read same line, P write+read line 0x100 higher
# columns: kind addr(hex) beats data_base(hex) expected_err
W 00000100 4 11110000 0
R 00000100 4 00000000 0
W 00000200 8 22220000 0
R 00000200 8 00000000 0
R 00000204 2 00000000 0
W 00000040 1 66660000 0
R 00000040 1 00000000 0
R 00000E00 4 00000000 1
R 00000E80 1 00000000 1
W 00000E40 4 33330000 1
R 00000100 2 00000000 0
H 00000300 4 44440000 0
H 00000308 2 77770000 0
W 00000500 4 88880000 0
P 00000400 4 55550000 0
P 00000600 2 99990000 0
R 00000600 2 00000000 0
W 00000100 4 AAAA0000 0
R 00000100 4 00000000 0

/* test/tb_l2_axi_bridge.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// run from the project root, patterns read from test/
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none
`include "l2_axi_params.svh"

module tb_l2_axi_bridge import l2_axi_pkg::*; ();
    localparam int TMO = 300; // cycles per operation

    logic clk = 1'b0;
    logic rstn = 1'b0;
    logic l2_rvalid = 0, l2_wvalid = 0, l2_wwvalid = 0, l2_wlast = 0, l2_bready = 0;
    logic [31:0] l2_raddr = 0, l2_waddr = 0, l2_wdata = 0;
    logic [7:0] l2_rlen = 0, l2_wlen = 0;
    logic [2:0] l2_rsize = 0, l2_wsize = 0;
    logic [3:0] l2_wstrb = 0;
    logic arready = 0, rvalid = 0, rlast = 0, awready = 0, wready = 0, bvalid = 0;
    logic [31:0] rdata = 0;
    axi_resp_t rresp = OKAY;
    axi_resp_t bresp = OKAY;
    logic l2_raddrOK, l2_rready, l2_rlast, l2_rerr, l2_waddrOK, l2_wready, l2_bvalid, l2_berr;
    logic [31:0] l2_rdata, araddr, awaddr, wdata;
    logic arvalid, rready, awvalid, wvalid, wlast, bready;
    logic [7:0] arlen, awlen;
    logic [2:0] arsize, awsize;
    logic [1:0] arburst, awburst;
    logic [3:0] wstrb;

    logic [31:0] mem [0:1023];     // subordinate storage
    logic [31:0] exp_mem [0:1023]; // what the L2 side expects
    int rd_st = 0, wr_st = 0, ar_wait = 0, r_wait = 0, aw_wait = 0, w_wait = 0, b_wait = 0;
    int rd_beat, wr_beat, ar_cnt = 0, aw_cnt = 0, errors = 0, rd_ops = 0, wr_ops = 0;
    logic [31:0] ar_addr_q, aw_addr_q;
    logic [7:0] ar_len_q, aw_len_q;
    logic [2:0] ar_size_q, aw_size_q;
    time ar_time = 0, b_time = 0;
    logic r_hs = 0, w_hs = 0, b_hs = 0, w_last_q = 0, overlap_seen = 0;
    logic [31:0] w_data_q = 0;
    logic [3:0] w_strb_q = 0;

    l2_axi_bridge l2_axi_bridge_i (.*);

    initial begin
        forever #50 clk = ~clk;
    end

    function automatic logic in_err_region(input logic [31:0] a);
        return a[11:8] == 4'hE;
    endfunction

    task automatic check_value(input string name, input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp) begin
            $display("CHECK FAILED t=%0t %s: got %h expected %h", $time, name, act, exp);
            errors++;
        end
    endtask

    // handshakes seen by the posedge, used by the model at the negedge
    always @(posedge clk) begin
        r_hs <= rvalid && rready;
        w_hs <= wvalid && wready;
        b_hs <= bvalid && bready;
        w_data_q <= wdata;
        w_strb_q <= wstrb;
        w_last_q <= wlast;
        if ((rd_st != 0 || arvalid) && (wr_st != 0 || awvalid)) overlap_seen <= 1'b1;
    end

    // read side of the subordinate
    always @(negedge clk) begin
        if (rstn) begin
            case (rd_st)
                0: if (arvalid) begin
                    if (ar_wait != 0) begin
                        ar_wait--;
                    end else begin
                        arready = 1'b1;
                        ar_cnt++;
                        ar_time = $time;
                        ar_addr_q = araddr;
                        ar_len_q = arlen;
                        ar_size_q = arsize;
                        check_value("arburst", arburst, AXI_BURST_INCR);
                        rd_beat = 0;
                        rd_st = 1;
                    end
                end
                1: begin
                    arready = 1'b0;
                    r_wait = $urandom % 4;
                    rd_st = 2;
                end
                default: begin
                    if (r_hs && rvalid) begin
                        rvalid = 1'b0;
                        rd_beat++;
                        r_wait = $urandom % 4;
                    end
                    if (rd_beat > ar_len_q) begin
                        rd_st = 0;
                        ar_wait = $urandom % 4;
                    end else if (!rvalid) begin
                        if (r_wait != 0) begin
                            r_wait--;
                        end else begin
                            rdata = mem[(ar_addr_q[11:2] + rd_beat) % 1024];
                            rresp = in_err_region(ar_addr_q) ? SLVERR : OKAY;
                            rlast = (rd_beat == ar_len_q);
                            rvalid = 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    // write side of the subordinate
    always @(negedge clk) begin
        if (rstn) begin
            case (wr_st)
                0: if (awvalid) begin
                    if (aw_wait != 0) begin
                        aw_wait--;
                    end else begin
                        awready = 1'b1;
                        aw_cnt++;
                        aw_addr_q = awaddr;
                        aw_len_q = awlen;
                        aw_size_q = awsize;
                        check_value("awburst", awburst, AXI_BURST_INCR);
                        wr_beat = 0;
                        wr_st = 1;
                    end
                end
                1: begin
                    awready = 1'b0;
                    w_wait = $urandom % 4;
                    wr_st = 2;
                end
                2: begin
                    if (w_hs && wready) begin
                        wready = 1'b0;
                        if (!in_err_region(aw_addr_q))
                            mem[(aw_addr_q[11:2] + wr_beat) % 1024] = w_data_q;
                        check_value("wlast", w_last_q, wr_beat == aw_len_q);
                        check_value("wstrb", w_strb_q, 4'hF);
                        wr_beat++;
                        w_wait = $urandom % 4;
                    end
                    if (wr_beat > aw_len_q) begin
                        wr_st = 3;
                        b_wait = $urandom % 4;
                    end else if (!wready) begin
                        if (w_wait != 0) w_wait--;
                        else wready = 1'b1;
                    end
                end
                default: begin
                    if (b_hs && bvalid) begin
                        bvalid = 1'b0;
                        b_time = $time;
                        wr_st = 0;
                        aw_wait = $urandom % 4;
                    end else if (!bvalid) begin
                        if (b_wait != 0) begin
                            b_wait--;
                        end else begin
                            bresp = in_err_region(aw_addr_q) ? SLVERR : OKAY;
                            bvalid = 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    task automatic do_write(input logic [31:0] addr, input int beats, input logic [31:0] base,
                            input logic err);
        int beat;
        int t;
        logic done;
        logic aw_taken;
        beat = 0;
        t = 0;
        done = 1'b0;
        aw_taken = 1'b0;
        wr_ops++;
        @(negedge clk);
        l2_waddr = addr;
        l2_wlen = beats - 1;
        l2_wsize = 3'd2;
        l2_wstrb = 4'hF;
        l2_wvalid = 1'b1;
        l2_wwvalid = 1'b1;
        l2_bready = 1'b1;
        l2_wdata = base;
        l2_wlast = (beats == 1);
        while (!done && t < TMO) begin
            @(posedge clk);
            t++;
            // address phase over until the last W beat
            check_value("l2_waddrOK", l2_waddrOK, aw_taken && (beat < beats));
            if (l2_wready) begin
                if (!err) exp_mem[(addr[11:2] + beat) % 1024] = base + beat;
                beat++;
            end
            if (l2_bvalid) begin
                check_value("l2_berr", l2_berr, err);
                done = 1'b1;
            end
            if (awvalid && awready) aw_taken = 1'b1;
            @(negedge clk);
            if (awvalid) l2_wvalid = 1'b0;
            l2_wdata = base + beat;
            l2_wlast = (beat == beats - 1);
            l2_wwvalid = (beat < beats);
        end
        if (!done) begin
            $display("timeout: write to %h never got its B response", addr);
            errors++;
        end
        l2_wvalid = 1'b0;
        l2_wwvalid = 1'b0;
        l2_wlast = 1'b0;
        l2_bready = 1'b0;
        check_value("write beats", beat, beats);
        check_value("aw count", aw_cnt, wr_ops);
        check_value("awaddr", aw_addr_q, addr);
        check_value("awlen", aw_len_q, beats - 1);
        check_value("awsize", aw_size_q, 2);
    endtask

    task automatic do_read(input logic [31:0] addr, input int beats, input logic err);
        int beat;
        int t;
        logic done;
        logic ar_taken;
        logic [31:0] exp;
        beat = 0;
        t = 0;
        done = 1'b0;
        ar_taken = 1'b0;
        rd_ops++;
        @(negedge clk);
        l2_raddr = addr;
        l2_rlen = beats - 1;
        l2_rsize = 3'd2;
        l2_rvalid = 1'b1;
        while (!done && t < TMO) begin
            @(posedge clk);
            t++;
            check_value("l2_raddrOK", l2_raddrOK, ar_taken); // high once AR is taken
            if (l2_rready) begin
                exp = err ? `L2_FILL_WORD : exp_mem[(addr[11:2] + beat) % 1024];
                check_value("l2_rdata", l2_rdata, exp);
                check_value("l2_rerr", l2_rerr, err);
                check_value("l2_rlast", l2_rlast, beat == beats - 1);
                beat++;
                if (l2_rlast) done = 1'b1;
            end
            if (arvalid && arready) ar_taken = 1'b1;
            @(negedge clk);
            if (arvalid) l2_rvalid = 1'b0; // request taken
        end
        if (!done) begin
            $display("timeout: read of %h never returned its last beat", addr);
            errors++;
        end
        l2_rvalid = 1'b0;
        check_value("read beats", beat, beats);
        check_value("ar count", ar_cnt, rd_ops);
        check_value("araddr", ar_addr_q, addr);
        check_value("arlen", ar_len_q, beats - 1);
        check_value("arsize", ar_size_q, 2);
    endtask

    initial begin
        int fd, code, beats, err;
        logic [7:0] kind;
        logic [31:0] addr, base;
        string line;
        void'($urandom(32'h1166));
        for (int i = 0; i < 1024; i++) begin
            mem[i] = 32'h5A000000 ^ (i << 2);
            exp_mem[i] = 32'h5A000000 ^ (i << 2);
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        fd = $fopen("test/l2_axi_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open the pattern file");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 1 && line[0] != "#") begin
                    code = $sscanf(line, "%c %h %d %h %d", kind, addr, beats, base, err);
                    overlap_seen = 1'b0;
                    if (kind == "W") begin
                        do_write(addr, beats, base, err[0]);
                    end else if (kind == "R") begin
                        do_read(addr, beats, err[0]);
                    end else begin
                        // H reads the line being written, P a line 0x100 higher
                        fork
                            do_write(addr, beats, base, err[0]);
                            begin
                                repeat (2) @(negedge clk);
                                do_read(kind == "H" ? addr : addr + 32'h100, beats, 1'b0);
                            end
                        join
                        if (kind == "H") check_value("ar after b", ar_time > b_time, 1);
                        else check_value("overlap", overlap_seen, 1);
                    end
                end
            end
            $fclose(fd);
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end
endmodule

`default_nettype wire
